//--- compile.f
common/exu_pkg.sv
common/exu_ifs.sv
exec/branch_unit.sv
exec/iter_multiplier.sv
exec/exec_unit.sv
src/operand_forward.sv
src/id_ex_reg.sv
src/exu_top.sv
sim/tb_exu.sv

//--- run.sh
#!/bin/sh
# build the execute stage testbench with verilator, run it, decide from the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing -j 0 --top-module tb_exu -f compile.f -o tb_exu_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_exu_sim > sim.log 2>&1
cat sim.log
grep -q "ALL CHECKS PASSED" sim.log && echo "result: pass" \
    || { echo "result: fail, see sim.log"; exit 1; }

//--- sim/tb_exu.sv
`timescale 1ns/1ps

module tb_exu;
    import exu_pkg::*;

    localparam int WAIT_MAX = 200;  // cycles, a full 64-step mul fits easily

    logic      clk;
    logic      reset;
    logic      valid_id_ex;
    logic      ready_id_ex;
    xlen_t     pc_id_ex;
    exu_op_e   op_id_ex;
    logic      use_imm_id_ex;
    reg_addr_t rd_id_ex;
    reg_addr_t rs1_id_ex;
    reg_addr_t rs2_id_ex;
    xlen_t     src_a;
    xlen_t     src_b;
    xlen_t     imm;
    logic      mem_wen;
    reg_addr_t mem_rd;
    xlen_t     mem_data;
    logic      wb_wen;
    reg_addr_t wb_rd;
    xlen_t     wb_data;
    logic      branch_flush;
    logic      valid_ex_mem;
    logic      ready_ex_mem;
    xlen_t     pc_ex_mem;
    reg_addr_t rd_ex_mem;
    xlen_t     result_ex_mem;
    xlen_t     dnpc;
    logic      pc_update;

    int n_checks;
    int n_errors;

    exu_top u_dut (.*);

    always #2 clk = ~clk;  // 4 ns period

    task automatic check_word(string name, xlen_t got, xlen_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_reg(string name, reg_addr_t got, reg_addr_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    function automatic xlen_t rand_word();
        return {$urandom(), $urandom()};
    endfunction

    function automatic xlen_t sext32(xlen_t v);
        return {{32{v[31]}}, v[31:0]};
    endfunction

    // reference results straight from the ISA definitions
    function automatic xlen_t model_result(exu_op_e op, xlen_t a, xlen_t b, xlen_t pc);
        xlen_t r;
        case (op)
            OP_ADD, OP_ADDW: r = a + b;
            OP_SUB, OP_SUBW: r = a - b;
            OP_AND:          r = a & b;
            OP_OR:           r = a | b;
            OP_XOR:          r = a ^ b;
            OP_SLL:          r = a << b[5:0];
            OP_SRL:          r = a >> b[5:0];
            OP_SRA:          r = xlen_t'($signed(a) >>> b[5:0]);
            OP_SLT:          r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            OP_SLTU:         r = (a < b) ? 64'd1 : 64'd0;
            OP_MUL, OP_MULW: r = a * b;         // low half only
            default:         r = pc + 64'd4;    // link for jal, jalr
        endcase
        return is_word_op(op) ? sext32(r) : r;
    endfunction

    function automatic logic model_taken(exu_op_e op, xlen_t a, xlen_t b);
        logic t;
        case (op)
            OP_BEQ:  t = (a == b);
            OP_BNE:  t = (a != b);
            OP_BLT:  t = ($signed(a) < $signed(b));
            OP_BGE:  t = !($signed(a) < $signed(b));
            OP_BLTU: t = (a < b);
            OP_BGEU: t = !(a < b);
            default: t = is_jump(op);
        endcase
        return t;
    endfunction

    function automatic xlen_t model_target(exu_op_e op, xlen_t a, xlen_t b, xlen_t pc,
                                           xlen_t im);
        xlen_t t;
        if (op == OP_JALR) begin
            t = (a + im) & ~64'd1;
        end else if (model_taken(op, a, b)) begin
            t = pc + im;
        end else begin
            t = pc + 64'd4;
        end
        return t;
    endfunction

    // drive one op, wait until the stage takes it, return on the next falling edge
    task automatic issue(exu_op_e op, logic use_i, reg_addr_t rd, reg_addr_t rs1,
                         reg_addr_t rs2, xlen_t a, xlen_t b, xlen_t im, xlen_t pc);
        int waited;
        waited = 0;
        @(negedge clk);
        valid_id_ex   = 1'b1;
        op_id_ex      = op;
        use_imm_id_ex = use_i;
        rd_id_ex      = rd;
        rs1_id_ex     = rs1;
        rs2_id_ex     = rs2;
        src_a         = a;
        src_b         = b;
        imm           = im;
        pc_id_ex      = pc;
        #1;
        while (!ready_id_ex && waited < WAIT_MAX) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!ready_id_ex) begin
            n_errors++;
            $display("ERROR t=%0t: stage never became ready to take %s", $time, op.name());
        end
        @(posedge clk);  // accepted here
        @(negedge clk);
        valid_id_ex = 1'b0;
    endtask

    task automatic wait_valid(string what);
        int cycles;
        cycles = 0;
        while (!valid_ex_mem && cycles < WAIT_MAX) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (!valid_ex_mem) begin
            n_errors++;
            $display("ERROR t=%0t: valid_ex_mem never rose for %s", $time, what);
        end
    endtask

    task automatic report_test(string name, int errs_before);
        $display("test %-14s %s, %0d errors", name,
                 (n_errors == errs_before) ? "ok" : "failed", n_errors - errs_before);
    endtask

    task automatic test_alu();
        int        start;
        exu_op_e   op;
        logic      use_i;
        xlen_t     a;
        xlen_t     b;
        xlen_t     im;
        reg_addr_t rd;
        start = n_errors;
        for (int i = 0; i <= int'(OP_SUBW); i++) begin
            for (int f = 0; f < 2; f++) begin
                op    = exu_op_e'(i);
                use_i = (f == 1);       // second pass is the immediate form
                a     = rand_word();
                b     = rand_word();
                im    = rand_word();
                rd    = reg_addr_t'($urandom_range(1, 31));
                issue(op, use_i, rd, 5'd1, 5'd2, a, b, im, 64'h1000);
                #1;
                check_bit("valid_ex_mem", valid_ex_mem, 1'b1);
                check_reg("rd_ex_mem", rd_ex_mem, rd);
                check_word($sformatf("result_ex_mem %s", op.name()), result_ex_mem,
                           model_result(op, a, use_i ? im : b, 64'h1000));
            end
        end
        report_test("alu", start);
    endtask

    function automatic xlen_t pick(int sel, xlen_t reg_v, xlen_t m, xlen_t w);
        xlen_t v;
        case (sel)
            1:       v = m;
            2:       v = w;
            default: v = reg_v;
        endcase
        return v;
    endfunction

    // sel 0 register value, 1 mem bypass, 2 wb bypass
    task automatic fwd_case(reg_addr_t rs1, reg_addr_t rs2, reg_addr_t mrd, reg_addr_t wrd,
                            int sel_a, int sel_b);
        xlen_t ra;
        xlen_t rb;
        xlen_t md;
        xlen_t wd;
        ra = rand_word();
        rb = rand_word();
        md = rand_word();
        wd = rand_word();
        @(negedge clk);
        mem_wen  = 1'b1;
        mem_rd   = mrd;
        mem_data = md;
        wb_wen   = 1'b1;
        wb_rd    = wrd;
        wb_data  = wd;
        issue(OP_ADD, 1'b0, 5'd10, rs1, rs2, ra, rb, '0, 64'h2000);
        #1;
        check_word("result_ex_mem", result_ex_mem,
                   pick(sel_a, ra, md, wd) + pick(sel_b, rb, md, wd));
    endtask

    task automatic test_forward();
        int start;
        start = n_errors;
        fwd_case(5'd5, 5'd6, 5'd5, 5'd5, 1, 0);  // mem beats wb
        fwd_case(5'd5, 5'd6, 5'd9, 5'd6, 0, 2);  // wb only
        fwd_case(5'd7, 5'd8, 5'd8, 5'd7, 2, 1);  // one of each
        fwd_case(5'd0, 5'd0, 5'd0, 5'd0, 0, 0);  // x0 never bypassed
        fwd_case(5'd3, 5'd4, 5'd7, 5'd8, 0, 0);  // no match
        @(negedge clk);
        mem_wen = 1'b0;
        wb_wen  = 1'b0;
        report_test("forward", start);
    endtask

    task automatic test_branch();
        int      start;
        exu_op_e op;
        xlen_t   pa [5];
        xlen_t   pb [5];
        xlen_t   pc;
        xlen_t   im;
        start = n_errors;
        pa[0] = rand_word();
        pb[0] = pa[0];                    // equal
        pa[1] = 64'd1;
        pb[1] = 64'd2;                    // less
        pa[2] = 64'd2;
        pb[2] = 64'd1;                    // greater
        pa[3] = 64'hffff_ffff_ffff_ffff;  // -1 vs 1, signed and unsigned differ
        pb[3] = 64'd1;
        pa[4] = 64'd1;
        pb[4] = 64'hffff_ffff_ffff_ffff;
        for (int i = int'(OP_BEQ); i <= int'(OP_JALR); i++) begin
            for (int k = 0; k < 5; k++) begin
                op = exu_op_e'(i);
                pc = rand_word() & ~64'd3;
                im = rand_word() & 64'h0000_0000_0000_fffe;
                if (op == OP_JALR) begin
                    pa[k] = pa[k] | 64'd1;  // odd target, bit 0 must clear
                end
                issue(op, 1'b0, is_jump(op) ? 5'd1 : 5'd0, 5'd1, 5'd2, pa[k], pb[k], im, pc);
                #1;
                check_bit($sformatf("pc_update %s", op.name()), pc_update,
                          model_taken(op, pa[k], pb[k]));
                check_word("dnpc", dnpc, model_target(op, pa[k], pb[k], pc, im));
                if (is_jump(op)) begin
                    check_word("result_ex_mem", result_ex_mem,
                               model_result(op, pa[k], pb[k], pc));
                end
            end
        end
        report_test("branch", start);
    endtask

    task automatic test_mul();
        int      start;
        exu_op_e op;
        xlen_t   a;
        xlen_t   b;
        start = n_errors;
        for (int i = 0; i < 6; i++) begin
            op = (i % 2 == 0) ? OP_MUL : OP_MULW;
            a  = rand_word();
            b  = rand_word();
            issue(op, 1'b0, 5'd12, 5'd1, 5'd2, a, b, '0, 64'h3000);
            #1;
            check_bit("ready_id_ex", ready_id_ex, 1'b0);  // busy multiplying
            check_bit("valid_ex_mem", valid_ex_mem, 1'b0);
            wait_valid(op.name());
            check_word($sformatf("result_ex_mem %s", op.name()), result_ex_mem,
                       model_result(op, a, b, 64'h3000));
            check_reg("rd_ex_mem", rd_ex_mem, 5'd12);
            check_bit("ready_id_ex", ready_id_ex, 1'b1);
        end
        report_test("mul", start);
    endtask

    task automatic test_stall_flush();
        int    start;
        xlen_t a;
        xlen_t b;
        start = n_errors;
        a = rand_word();
        b = rand_word();
        issue(OP_XOR, 1'b0, 5'd4, 5'd1, 5'd2, a, b, '0, 64'h4000);
        ready_ex_mem = 1'b0;
        pc_id_ex     = 64'h4100;  // decode side moves on, stage must not load it
        src_a        = ~a;
        repeat (3) begin
            #1;
            check_bit("ready_id_ex", ready_id_ex, 1'b0);
            check_bit("valid_ex_mem", valid_ex_mem, 1'b1);
            check_word("result_ex_mem", result_ex_mem, a ^ b);
            check_word("pc_ex_mem", pc_ex_mem, 64'h4000);
            @(negedge clk);
        end
        ready_ex_mem = 1'b1;
        // taken branch held back, redirect only once released
        issue(OP_BEQ, 1'b0, 5'd0, 5'd1, 5'd2, a, a, 64'h40, 64'h5000);
        ready_ex_mem = 1'b0;
        repeat (3) begin
            #1;
            check_bit("pc_update", pc_update, 1'b0);
            @(negedge clk);
        end
        ready_ex_mem = 1'b1;
        #1;
        check_bit("pc_update", pc_update, 1'b1);
        check_word("dnpc", dnpc, 64'h5040);
        // flush a held add
        issue(OP_ADD, 1'b0, 5'd4, 5'd1, 5'd2, a, b, '0, 64'h6000);
        ready_ex_mem = 1'b0;
        branch_flush = 1'b1;
        #1;
        check_bit("valid_ex_mem", valid_ex_mem, 1'b1);
        @(negedge clk);
        branch_flush = 1'b0;
        ready_ex_mem = 1'b1;
        #1;
        check_bit("valid_ex_mem", valid_ex_mem, 1'b0);
        // flush in the middle of a multiply
        issue(OP_MUL, 1'b0, 5'd4, 5'd1, 5'd2, a, b, '0, 64'h7000);
        repeat (4) @(negedge clk);
        branch_flush = 1'b1;
        #1;
        check_bit("ready_id_ex", ready_id_ex, 1'b0);
        @(negedge clk);
        branch_flush = 1'b0;
        #1;
        check_bit("valid_ex_mem", valid_ex_mem, 0);
        check_bit("ready_id_ex", ready_id_ex, 1'b1);
        issue(OP_ADD, 1'b0, 5'd9, 5'd1, 5'd2, a, b, '0, 64'h8000);
        #1;
        check_bit("valid_ex_mem", valid_ex_mem, 1'b1);
        check_word("result_ex_mem", result_ex_mem, a + b);
        // multiplier starts over after the abort
        a = rand_word();
        b = rand_word();
        issue(OP_MUL, 1'b0, 5'd11, 5'd1, 5'd2, a, b, '0, 64'h9000);
        wait_valid("mul after flush");
        check_word("result_ex_mem", result_ex_mem, a * b);
        check_reg("rd_ex_mem", rd_ex_mem, 5'd11);
        report_test("stall_flush", start);
    endtask

    initial begin
        void'($urandom(32'he4e4_c45e));
        n_checks      = 0;
        n_errors      = 0;
        clk           = 1'b0;
        reset         = 1'b1;
        valid_id_ex   = 1'b0;
        pc_id_ex      = '0;
        op_id_ex      = OP_ADD;
        use_imm_id_ex = 1'b0;
        rd_id_ex      = '0;
        rs1_id_ex     = '0;
        rs2_id_ex     = '0;
        src_a         = '0;
        src_b         = '0;
        imm           = '0;
        mem_wen       = 1'b0;
        mem_rd        = '0;
        mem_data      = '0;
        wb_wen        = 1'b0;
        wb_rd         = '0;
        wb_data       = '0;
        branch_flush  = 1'b0;
        ready_ex_mem  = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        check_bit("valid_ex_mem", valid_ex_mem, 1'b0);
        check_bit("pc_update", pc_update, 1'b0);
        check_bit("ready_id_ex", ready_id_ex, 1'b1);
        report_test("reset", 0);
        test_alu();
        test_forward();
        test_branch();
        test_mul();
        test_stall_flush();
        $display("checks run %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- src/exu_top.sv
`timescale 1ns/1ps

module exu_top #(
    parameter int MUL_W = exu_pkg::XLEN
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               valid_id_ex,
    output logic               ready_id_ex,
    input  exu_pkg::xlen_t     pc_id_ex,
    input  exu_pkg::exu_op_e   op_id_ex,
    input  logic               use_imm_id_ex,
    input  exu_pkg::reg_addr_t rd_id_ex,
    input  exu_pkg::reg_addr_t rs1_id_ex,
    input  exu_pkg::reg_addr_t rs2_id_ex,
    input  exu_pkg::xlen_t     src_a,
    input  exu_pkg::xlen_t     src_b,
    input  exu_pkg::xlen_t     imm,
    input  logic               mem_wen,
    input  exu_pkg::reg_addr_t mem_rd,
    input  exu_pkg::xlen_t     mem_data,
    input  logic               wb_wen,
    input  exu_pkg::reg_addr_t wb_rd,
    input  exu_pkg::xlen_t     wb_data,
    input  logic               branch_flush,
    output logic               valid_ex_mem,
    input  logic               ready_ex_mem,
    output exu_pkg::xlen_t     pc_ex_mem,
    output exu_pkg::reg_addr_t rd_ex_mem,
    output exu_pkg::xlen_t     result_ex_mem,
    output exu_pkg::xlen_t     dnpc,
    output logic               pc_update
);
    import exu_pkg::*;

    reg_addr_t fwd_rs  [2];  // 0 is rs1, 1 is rs2
    xlen_t     fwd_reg [2];  // register file values from decode
    xlen_t     opnd    [2];  // after bypass

    ex_issue_if issue ();
    bypass_if   byp ();

    // bypass sources straight from the later stages
    assign byp.mem_wen  = mem_wen;
    assign byp.mem_rd   = mem_rd;
    assign byp.mem_data = mem_data;
    assign byp.wb_wen   = wb_wen;
    assign byp.wb_rd    = wb_rd;
    assign byp.wb_data  = wb_data;

    assign fwd_rs[0]  = issue.rs1;
    assign fwd_rs[1]  = issue.rs2;
    assign fwd_reg[0] = issue.src_a;
    assign fwd_reg[1] = issue.src_b;

    id_ex_reg u_id_ex_reg (
        .clk        (clk),
        .reset      (reset),
        .flush      (branch_flush),
        .advance    (ready_id_ex),  // stage moves when it can accept
        .valid_in   (valid_id_ex),
        .pc_in      (pc_id_ex),
        .op_in      (op_id_ex),
        .use_imm_in (use_imm_id_ex),
        .rd_in      (rd_id_ex),
        .rs1_in     (rs1_id_ex),
        .rs2_in     (rs2_id_ex),
        .src_a_in   (src_a),
        .src_b_in   (src_b),
        .imm_in     (imm),
        .issue      (issue.stage)
    );

    for (genvar i = 0; i < 2; i++) begin : g_fwd
        operand_forward u_fwd (
            .rs      (fwd_rs[i]),
            .reg_val (fwd_reg[i]),
            .byp     (byp.fwd),
            .fwd_val (opnd[i])
        );
    end

    exec_unit #(
        .MUL_W (MUL_W)
    ) u_exec (
        .clk           (clk),
        .reset         (reset),
        .issue         (issue.exec),
        .opnd          (opnd),
        .ready_ex_mem  (ready_ex_mem),
        .flush         (branch_flush),
        .ready_id_ex   (ready_id_ex),
        .valid_ex_mem  (valid_ex_mem),
        .pc_ex_mem     (pc_ex_mem),
        .rd_ex_mem     (rd_ex_mem),
        .result_ex_mem (result_ex_mem),
        .dnpc          (dnpc),
        .pc_update     (pc_update)
    );

endmodule

//--- src/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,      // taken redirect upstream
    input  logic               advance,    // load new bundle, else hold
    input  logic               valid_in,
    input  exu_pkg::xlen_t     pc_in,
    input  exu_pkg::exu_op_e   op_in,
    input  logic               use_imm_in,
    input  exu_pkg::reg_addr_t rd_in,
    input  exu_pkg::reg_addr_t rs1_in,
    input  exu_pkg::reg_addr_t rs2_in,
    input  exu_pkg::xlen_t     src_a_in,
    input  exu_pkg::xlen_t     src_b_in,
    input  exu_pkg::xlen_t     imm_in,
    ex_issue_if.stage          issue
);
    import exu_pkg::*;

    // whole bundle cleared on reset or flush, a bubble looks like add x0
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            issue.valid   <= 1'b0;
            issue.pc      <= '0;
            issue.op      <= OP_ADD;
            issue.use_imm <= 1'b0;
            issue.rd      <= '0;
            issue.rs1     <= '0;
            issue.rs2     <= '0;
            issue.src_a   <= '0;
            issue.src_b   <= '0;
            issue.imm     <= '0;
        end else if (advance) begin
            // bubble in gives valid low, fields still loaded
            issue.valid   <= valid_in;
            issue.pc      <= pc_in;
            issue.op      <= op_in;
            issue.use_imm <= use_imm_in;
            issue.rd      <= rd_in;
            issue.rs1     <= rs1_in;
            issue.rs2     <= rs2_in;
            issue.src_a   <= src_a_in;
            issue.src_b   <= src_b_in;
            issue.imm     <= imm_in;
        end
        // otherwise hold, stalled on mul or back-pressure
    end

endmodule

//--- src/operand_forward.sv
`timescale 1ns/1ps

module operand_forward (
    input  exu_pkg::reg_addr_t rs,       // source index held in the stage
    input  exu_pkg::xlen_t     reg_val,  // value read in decode
    bypass_if.fwd              byp,
    output exu_pkg::xlen_t     fwd_val
);

    logic rs_live;   // x0 never forwarded
    logic mem_hit;
    logic wb_hit;

    assign rs_live = (rs != '0);
    assign mem_hit = byp.mem_wen && (byp.mem_rd == rs) && rs_live;
    assign wb_hit  = byp.wb_wen && (byp.wb_rd == rs) && rs_live;

    // mem stage is younger, so it wins over wb
    always_comb begin
        if (mem_hit) begin
            fwd_val = byp.mem_data;
        end else if (wb_hit) begin
            fwd_val = byp.wb_data;
        end else begin
            fwd_val = reg_val;
        end
    end

endmodule

//--- exec/exec_unit.sv
`timescale 1ns/1ps

module exec_unit #(
    parameter int MUL_W = exu_pkg::XLEN
) (
    input  logic               clk,
    input  logic               reset,
    ex_issue_if.exec           issue,
    input  exu_pkg::xlen_t     opnd [2],     // forwarded rs1, rs2
    input  logic               ready_ex_mem,
    input  logic               flush,
    output logic               ready_id_ex,  // also the stage advance
    output logic               valid_ex_mem,
    output exu_pkg::xlen_t     pc_ex_mem,
    output exu_pkg::reg_addr_t rd_ex_mem,
    output exu_pkg::xlen_t     result_ex_mem,
    output exu_pkg::xlen_t     dnpc,
    output logic               pc_update
);
    import exu_pkg::*;

    xlen_t            op_b;
    logic [5:0]       shamt;
    xlen_t            alu_res;
    xlen_t            alu_word;     // alu result, word form
    logic             mul_op;
    logic             mul_wait;
    logic             mul_start;
    logic             mul_consume;
    logic             mul_done;
    logic [MUL_W-1:0] mul_a;
    logic [MUL_W-1:0] mul_b;
    logic [MUL_W-1:0] mul_p;
    xlen_t            mul_res;

    assign op_b  = issue.use_imm ? issue.imm : opnd[1];
    assign shamt = is_word_op(issue.op) ? {1'b0, op_b[4:0]} : op_b[5:0];  // 5 bits for word

    always_comb begin
        case (issue.op)
            OP_ADD, OP_ADDW: alu_res = opnd[0] + op_b;
            OP_SUB, OP_SUBW: alu_res = opnd[0] - op_b;
            OP_AND:  alu_res = opnd[0] & op_b;
            OP_OR:   alu_res = opnd[0] | op_b;
            OP_XOR:  alu_res = opnd[0] ^ op_b;
            OP_SLL:  alu_res = opnd[0] << shamt;
            OP_SRL:  alu_res = opnd[0] >> shamt;
            OP_SRA:  alu_res = xlen_t'($signed(opnd[0]) >>> shamt);
            OP_SLT:  alu_res = xlen_t'($signed(opnd[0]) < $signed(op_b));
            OP_SLTU: alu_res = xlen_t'(opnd[0] < op_b);
            default: alu_res = opnd[0] + op_b;  // branch/jump/mul, not selected
        endcase
    end

    assign alu_word = {{(XLEN-32){alu_res[31]}}, alu_res[31:0]};

    // mul in the stage and product not ready yet
    assign mul_op      = issue.valid && is_mul(issue.op);
    assign mul_wait    = mul_op && !mul_done;
    assign mul_start   = mul_op && ready_ex_mem && !mul_done;  // ignored while busy
    assign mul_consume = mul_op && mul_done && ready_ex_mem;   // stage advancing

    assign ready_id_ex  = ready_ex_mem && !mul_wait;
    assign valid_ex_mem = issue.valid && !mul_wait;
    assign pc_ex_mem    = issue.pc;
    assign rd_ex_mem    = issue.rd;

    assign mul_a   = MUL_W'(opnd[0]);
    assign mul_b   = MUL_W'(opnd[1]);  // mul is register form only
    assign mul_res = xlen_t'(mul_p);

    always_comb begin
        if (is_jump(issue.op)) begin
            result_ex_mem = issue.pc + 64'd4;  // link address
        end else if (issue.op == OP_MULW) begin
            result_ex_mem = {{(XLEN-32){mul_res[31]}}, mul_res[31:0]};
        end else if (issue.op == OP_MUL) begin
            result_ex_mem = mul_res;           // low half only
        end else if (is_word_op(issue.op)) begin
            result_ex_mem = alu_word;
        end else begin
            result_ex_mem = alu_res;
        end
    end

    branch_unit u_branch (
        .op           (issue.op),
        .valid        (issue.valid),
        .ready_ex_mem (ready_ex_mem),
        .pc           (issue.pc),
        .a            (opnd[0]),
        .b            (opnd[1]),
        .imm          (issue.imm),
        .dnpc         (dnpc),
        .pc_update    (pc_update)
    );

    iter_multiplier #(
        .MUL_W (MUL_W)
    ) u_mul (
        .clk     (clk),
        .reset   (reset),
        .start   (mul_start),
        .abort   (flush),             // flushed mul dropped mid-flight
        .consume (mul_consume),
        .word    (issue.op == OP_MULW),
        .a       (mul_a),
        .b       (mul_b),
        .done    (mul_done),
        .product (mul_p)
    );

endmodule

//--- exec/iter_multiplier.sv
`timescale 1ns/1ps

module iter_multiplier #(
    parameter int MUL_W = 64
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,    // taken only when idle
    input  logic             abort,
    input  logic             consume,  // releases a held result
    input  logic             word,     // half the iterations
    input  logic [MUL_W-1:0] a,
    input  logic [MUL_W-1:0] b,
    output logic             done,
    output logic [MUL_W-1:0] product
);

    localparam int CNT_W = $clog2(MUL_W);

    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] last;    // index of final iteration
    logic [MUL_W-1:0] mcand;   // shifts left
    logic [MUL_W-1:0] mplier;  // shifts right, lsb picks the add
    logic [MUL_W-1:0] acc;

    always_ff @(posedge clk) begin
        if (reset || abort) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
            last <= '0;
        end else if (busy) begin
            cnt <= cnt + 1'b1;
            if (cnt == last) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end else if (done) begin
            if (consume) begin
                done <= 1'b0;
            end
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= '0;
            last <= word ? CNT_W'(MUL_W/2 - 1) : CNT_W'(MUL_W - 1);
        end
    end

    // low half only, upper bits fall off the shift
    always_ff @(posedge clk) begin
        if (!busy && !done && start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign product = acc;  // stable from done until next start

endmodule

//--- exec/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  exu_pkg::exu_op_e op,
    input  logic             valid,
    input  logic             ready_ex_mem,
    input  exu_pkg::xlen_t   pc,
    input  exu_pkg::xlen_t   a,          // rs1, forwarded
    input  exu_pkg::xlen_t   b,          // rs2, forwarded
    input  exu_pkg::xlen_t   imm,
    output exu_pkg::xlen_t   dnpc,
    output logic             pc_update
);
    import exu_pkg::*;

    logic cond;
    logic taken;

    always_comb begin
        case (op)
            OP_BEQ:  cond = (a == b);
            OP_BNE:  cond = (a != b);
            OP_BLT:  cond = ($signed(a) < $signed(b));
            OP_BGE:  cond = ($signed(a) >= $signed(b));
            OP_BLTU: cond = (a < b);
            OP_BGEU: cond = (a >= b);
            default: cond = 1'b0;
        endcase
    end

    assign taken = is_jump(op) || (is_branch(op) && cond);

    always_comb begin
        if (op == OP_JALR) begin
            dnpc = (a + imm) & ~xlen_t'(1);  // bit 0 cleared
        end else if (taken) begin
            dnpc = pc + imm;                 // jal and taken branches
        end else begin
            dnpc = pc + 64'd4;
        end
    end

    // redirect only once the op can leave the stage
    assign pc_update = valid && ready_ex_mem && taken;

endmodule

//--- common/exu_ifs.sv
`timescale 1ns/1ps

// decoded op as held in the execute stage register
interface ex_issue_if;
    import exu_pkg::*;

    logic      valid;    // stage holds an op
    xlen_t     pc;
    exu_op_e   op;
    logic      use_imm;  // operand b from imm instead of rs2
    reg_addr_t rd;
    reg_addr_t rs1;      // source indices, for bypass match
    reg_addr_t rs2;
    xlen_t     src_a;    // register file values read in decode
    xlen_t     src_b;
    xlen_t     imm;

    modport stage (
        output valid, pc, op, use_imm, rd, rs1, rs2, src_a, src_b, imm
    );
    modport exec (
        input valid, pc, op, use_imm, rd, imm
    );
    modport fwd (
        input rs1, rs2, src_a, src_b
    );
endinterface

// results still in flight in the memory and writeback stages
interface bypass_if;
    import exu_pkg::*;

    logic      mem_wen;   // mem stage will write rd
    reg_addr_t mem_rd;
    xlen_t     mem_data;
    logic      wb_wen;    // wb stage writing this cycle
    reg_addr_t wb_rd;
    xlen_t     wb_data;

    modport src (
        output mem_wen, mem_rd, mem_data, wb_wen, wb_rd, wb_data
    );
    modport fwd (
        input mem_wen, mem_rd, mem_data, wb_wen, wb_rd, wb_data
    );
endinterface

//--- common/exu_pkg.sv
package exu_pkg;

    localparam int XLEN       = 64;  // data path width
    localparam int REG_ADDR_W = 5;   // x0..x31

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // one value per instruction the stage executes
    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_ADDW,
        OP_SUBW,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_JAL,
        OP_JALR,
        OP_MUL,
        OP_MULW
    } exu_op_e;

    // conditional branches only, jumps are separate
    function automatic logic is_branch(exu_op_e op);
        return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    endfunction

    function automatic logic is_jump(exu_op_e op);
        return op inside {OP_JAL, OP_JALR};
    endfunction

    function automatic logic is_mul(exu_op_e op);
        return op inside {OP_MUL, OP_MULW};
    endfunction

    // 32-bit ops, result sign-extended from bit 31
    function automatic logic is_word_op(exu_op_e op);
        return op inside {OP_ADDW, OP_SUBW, OP_MULW};
    endfunction

endpackage
